//--- mcu_pkg.sv
`default_nettype none

package mcu_pkg;

  // ------------------------------
  // Bus vector types
  // ------------------------------
  typedef logic [31:0] haddr_t;   // Byte address
  typedef logic [31:0] hdata_t;   // Read and write data
  typedef logic [1:0]  htrans_t;  // Transfer type
  typedef logic [2:0]  hsize_t;   // Transfer size
  typedef logic [11:0] rofs_t;    // Offset inside one 4 KiB region
  typedef logic [15:0] gpio_t;    // Pins of one port

  // ------------------------------
  // AHB-Lite encodings
  // ------------------------------
  localparam htrans_t HTRANS_IDLE   = 2'b00;  // No transfer
  localparam htrans_t HTRANS_NONSEQ = 2'b10;  // Single transfer

  localparam hsize_t HSIZE_BYTE = 3'b000;  // 1 byte
  localparam hsize_t HSIZE_HALF = 3'b001;  // 2 bytes
  localparam hsize_t HSIZE_WORD = 3'b010;  // 4 bytes

  // ------------------------------
  // Address map
  // ------------------------------
  // Each region is decoded on the upper 20 address bits
  localparam haddr_t REGION_MASK = 32'hFFFF_F000;

  localparam haddr_t BASE_ROM   = 32'h0000_0000;  // Program memory
  localparam haddr_t BASE_SRAM  = 32'h2000_0000;  // Data memory
  localparam haddr_t BASE_GPIO0 = 32'h4001_0000;  // Port 0
  localparam haddr_t BASE_GPIO1 = 32'h4001_1000;  // Port 1

  // GPIO register offsets
  localparam rofs_t GPIO_DATA_OFS = 12'h000;  // Synchronized pin input, RO
  localparam rofs_t GPIO_DOUT_OFS = 12'h004;  // Output data
  localparam rofs_t GPIO_OEN_OFS  = 12'h008;  // Output enable

endpackage

`default_nettype wire

//--- mcu_clkctrl.sv
`default_nettype none

module mcu_clkctrl #(
  parameter int RST_HOLD = 4  // Reset cycles after request ends
) (
  input  wire  i_hclk,           // System clock
  input  wire  i_rst_n,          // External reset pin
  input  wire  i_sys_reset_req,  // Combined system reset request
  output logic o_poreset_n,      // Synchronized power-on reset
  output logic o_hreset_n        // System reset for bus and peripherals
);

  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic [1:0]       por_sync;  // Release synchronizer
  logic [CNT_W-1:0] hold_cnt;  // Cycles left to hold
  logic             hrst_q;    // Registered system reset

  // ------------------------------
  // Power-on reset
  // ------------------------------
  // Assert at once, release after two edges
  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      por_sync <= '0;
    end else begin
      por_sync <= {por_sync[0], 1'b1};  // Shift in release
    end
  end

  assign o_poreset_n = por_sync[1];

  // ------------------------------
  // System reset sequencer
  // ------------------------------
  // Power-on reset also clears this stage, so HRESETn follows PORESETn
  always_ff @(posedge i_hclk or negedge o_poreset_n) begin
    if (!o_poreset_n) begin
      hold_cnt <= '0;
      hrst_q   <= 1'b0;
    end else if (i_sys_reset_req) begin
      hold_cnt <= CNT_W'(RST_HOLD);  // Reload while request present
      hrst_q   <= 1'b0;              // Drop one cycle after request
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;   // Count down hold time
      hrst_q   <= (hold_cnt == CNT_W'(1));  // Release on last count
    end else begin
      hrst_q   <= 1'b1;              // Normal run
    end
  end

  assign o_hreset_n = hrst_q;

endmodule

`default_nettype wire

//--- mcu_ahb_decoder.sv
`default_nettype none

module mcu_ahb_decoder (
  input  wire              i_hclk,         // System clock
  input  wire              i_hreset_n,     // System reset
  input  wire mcu_pkg::haddr_t  i_haddr,   // Bus address
  input  wire mcu_pkg::htrans_t i_htrans,  // Transfer type
  input  wire mcu_pkg::hdata_t  i_rom_rdata,
  input  wire mcu_pkg::hdata_t  i_sram_rdata,
  input  wire mcu_pkg::hdata_t  i_gpio0_rdata,
  input  wire mcu_pkg::hdata_t  i_gpio1_rdata,
  output logic             o_sel_rom,      // Address-phase selects
  output logic             o_sel_sram,
  output logic             o_sel_gpio0,
  output logic             o_sel_gpio1,
  output mcu_pkg::hdata_t  o_hrdata,       // Muxed read data
  output logic             o_hready,       // Bus ready
  output logic             o_hresp         // Error response
);

  // Default slave response sequence
  typedef enum logic [1:0] {
    ST_IDLE,  // OKAY, ready
    ST_ERR1,  // ERROR, stall
    ST_ERR2   // ERROR, ready
  } dec_state_t;

  dec_state_t      state;
  dec_state_t      state_nxt;
  mcu_pkg::haddr_t region;    // Address with offset cleared
  logic            start;     // Valid address phase
  logic            hit_rom;
  logic            hit_sram;
  logic            hit_gpio0;
  logic            hit_gpio1;
  logic            unmapped;  // Transfer to no slave
  logic [3:0]      dsel_q;    // Data-phase region {gpio1, gpio0, sram, rom}

  // ------------------------------
  // Address phase
  // ------------------------------
  assign start  = (i_htrans == mcu_pkg::HTRANS_NONSEQ) && o_hready;
  assign region = i_haddr & mcu_pkg::REGION_MASK;

  assign hit_rom   = (region == mcu_pkg::BASE_ROM);
  assign hit_sram  = (region == mcu_pkg::BASE_SRAM);
  assign hit_gpio0 = (region == mcu_pkg::BASE_GPIO0);
  assign hit_gpio1 = (region == mcu_pkg::BASE_GPIO1);

  assign o_sel_rom   = start & hit_rom;
  assign o_sel_sram  = start & hit_sram;
  assign o_sel_gpio0 = start & hit_gpio0;
  assign o_sel_gpio1 = start & hit_gpio1;
  assign unmapped    = start & ~(hit_rom | hit_sram | hit_gpio0 | hit_gpio1);

  // Region held for the data phase
  always_ff @(posedge i_hclk or negedge i_hreset_n) begin
    if (!i_hreset_n) begin
      dsel_q <= '0;
    end else if (o_hready) begin
      dsel_q <= {o_sel_gpio1, o_sel_gpio0, o_sel_sram, o_sel_rom};
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------
  always_comb begin
    case (dsel_q)
      4'b0001: o_hrdata = i_rom_rdata;
      4'b0010: o_hrdata = i_sram_rdata;
      4'b0100: o_hrdata = i_gpio0_rdata;
      4'b1000: o_hrdata = i_gpio1_rdata;
      default: o_hrdata = '0;  // Idle or default slave
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (unmapped) state_nxt = ST_ERR1;
      ST_ERR1: state_nxt = ST_ERR2;                       // Second error cycle
      ST_ERR2: state_nxt = unmapped ? ST_ERR1 : ST_IDLE;  // Back to back error
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_hreset_n) begin
    if (!i_hreset_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_hready = (state != ST_ERR1);
  assign o_hresp  = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- mcu_ahb_rom.sv
`default_nettype none

module mcu_ahb_rom #(
  parameter int ROM_AW = 4  // Word address width
) (
  input  wire                  i_hclk,    // System clock
  input  wire                  i_sel,     // Address-phase select
  input  wire mcu_pkg::haddr_t i_haddr,   // Bus address
  output mcu_pkg::hdata_t      o_hrdata   // Read data
);

  localparam int DEPTH = 2 ** ROM_AW;

  mcu_pkg::hdata_t   mem [DEPTH];  // Program image
  logic [ROM_AW-1:0] word_q;       // Data-phase word address

  // Program content
  initial begin
    $readmemh("rom.hex", mem);
  end

  // ------------------------------
  // Address phase
  // ------------------------------
  // Upper bits dropped, so the image wraps in its region
  always_ff @(posedge i_hclk) begin
    if (i_sel) begin
      word_q <= i_haddr[ROM_AW+1:2];  // Word index
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------
  // Writes land here too and just read the word back
  assign o_hrdata = mem[word_q];

endmodule

`default_nettype wire

//--- mcu_ahb_sram.sv
`default_nettype none

module mcu_ahb_sram #(
  parameter int SRAM_AW = 8  // Word address width
) (
  input  wire                  i_hclk,    // System clock
  input  wire                  i_sel,     // Address-phase select
  input  wire                  i_hwrite,  // Write transfer
  input  wire mcu_pkg::haddr_t i_haddr,   // Bus address
  input  wire mcu_pkg::hsize_t i_hsize,   // Transfer size
  input  wire mcu_pkg::hdata_t i_hwdata,  // Write data, data phase
  output mcu_pkg::hdata_t      o_hrdata   // Read data
);

  localparam int DEPTH = 2 ** SRAM_AW;

  mcu_pkg::hdata_t    mem [DEPTH];  // Storage, never cleared
  logic [SRAM_AW-1:0] word_q;       // Data-phase word address
  logic               we_q;         // Data-phase write
  logic [3:0]         lanes_q;      // Data-phase byte enables

  // Byte lanes touched by one transfer, little endian
  function automatic logic [3:0] lane_mask(input mcu_pkg::hsize_t size,
                                           input logic [1:0]      lo);
    logic [3:0] mask;
    case (size)
      mcu_pkg::HSIZE_BYTE: mask = 4'b0001 << lo;                   // One lane
      mcu_pkg::HSIZE_HALF: mask = lo[1] ? 4'b1100 : 4'b0011;       // Pair
      default:             mask = 4'b1111;                         // Word
    endcase
    return mask;
  endfunction

  // ------------------------------
  // Address phase
  // ------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_sel) begin
      word_q  <= i_haddr[SRAM_AW+1:2];  // Wraps past the top
      we_q    <= i_hwrite;
      lanes_q <= lane_mask(i_hsize, i_haddr[1:0]);
    end else begin
      we_q    <= 1'b0;  // No write without a transfer
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------
  // Only enabled lanes are stored at the end of the cycle
  always_ff @(posedge i_hclk) begin
    if (we_q) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes_q[i]) begin
          mem[word_q][8*i +: 8] <= i_hwdata[8*i +: 8];
        end
      end
    end
  end

  // Whole word always returned
  assign o_hrdata = mem[word_q];

endmodule

`default_nettype wire

//--- mcu_ahb_gpio.sv
`default_nettype none

module mcu_ahb_gpio (
  input  wire                  i_hclk,      // System clock
  input  wire                  i_hreset_n,  // System reset
  input  wire                  i_sel,       // Address-phase select
  input  wire                  i_hwrite,    // Write transfer
  input  wire mcu_pkg::haddr_t i_haddr,     // Bus address
  input  wire mcu_pkg::hsize_t i_hsize,     // Transfer size
  input  wire mcu_pkg::hdata_t i_hwdata,    // Write data, data phase
  input  wire mcu_pkg::gpio_t  i_pin,       // Pad input
  output mcu_pkg::hdata_t      o_hrdata,    // Register read data
  output mcu_pkg::gpio_t       o_pin_out,   // Pad output
  output mcu_pkg::gpio_t       o_pin_oe     // Pad output enable
);

  mcu_pkg::rofs_t ofs_q;     // Data-phase register offset
  logic           wr_q;      // Data-phase word write
  mcu_pkg::gpio_t dout_q;    // DOUT register
  mcu_pkg::gpio_t oen_q;     // OEN register
  mcu_pkg::gpio_t pin_meta;  // First sync stage
  mcu_pkg::gpio_t pin_sync;  // DATA register

  // ------------------------------
  // Address phase
  // ------------------------------
  always_ff @(posedge i_hclk or negedge i_hreset_n) begin
    if (!i_hreset_n) begin
      ofs_q <= '0;
      wr_q  <= 1'b0;
    end else begin
      if (i_sel) begin
        ofs_q <= i_haddr[11:0];  // Offset in region
      end
      // Byte and halfword writes dropped here
      wr_q <= i_sel & i_hwrite & (i_hsize == mcu_pkg::HSIZE_WORD);
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge i_hclk or negedge i_hreset_n) begin
    if (!i_hreset_n) begin
      dout_q <= '0;
      oen_q  <= '0;
    end else if (wr_q) begin
      case (ofs_q)
        mcu_pkg::GPIO_DOUT_OFS: dout_q <= i_hwdata[15:0];
        mcu_pkg::GPIO_OEN_OFS:  oen_q  <= i_hwdata[15:0];
        default: ;  // DATA is read only
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge i_hclk or negedge i_hreset_n) begin
    if (!i_hreset_n) begin
      pin_meta <= '0;
      pin_sync <= '0;
    end else begin
      pin_meta <= i_pin;
      pin_sync <= pin_meta;
    end
  end

  // Read back, upper half zero
  always_comb begin
    case (ofs_q)
      mcu_pkg::GPIO_DATA_OFS: o_hrdata = {16'h0000, pin_sync};
      mcu_pkg::GPIO_DOUT_OFS: o_hrdata = {16'h0000, dout_q};
      mcu_pkg::GPIO_OEN_OFS:  o_hrdata = {16'h0000, oen_q};
      default:                o_hrdata = '0;  // Unused offset
    endcase
  end

  // Pin driver, no alternate functions
  assign o_pin_out = dout_q;
  assign o_pin_oe  = oen_q;

endmodule

`default_nettype wire

//--- mcu_top.sv
`default_nettype none

module mcu_top #(
  parameter int ROM_AW   = 4,  // ROM word address width
  parameter int SRAM_AW  = 8,  // SRAM word address width, 1 KiB
  parameter int RST_HOLD = 4   // System reset hold cycles
) (
  input  wire                   i_hclk,         // System clock
  input  wire                   i_rst_n,        // Reset pin
  input  wire                   i_sysresetreq,  // Software reset request
  input  wire                   i_lockup,       // Core lockup
  input  wire                   i_lockupreset,  // Reset on lockup enable
  input  wire mcu_pkg::haddr_t  i_haddr,
  input  wire mcu_pkg::htrans_t i_htrans,
  input  wire mcu_pkg::hsize_t  i_hsize,
  input  wire                   i_hwrite,
  input  wire mcu_pkg::hdata_t  i_hwdata,
  input  wire mcu_pkg::gpio_t   i_p0_in,        // Port 0 pads
  input  wire mcu_pkg::gpio_t   i_p1_in,        // Port 1 pads
  output mcu_pkg::hdata_t       o_hrdata,
  output logic                  o_hready,
  output logic                  o_hresp,
  output logic                  o_sysrst_n,     // System reset out
  output mcu_pkg::gpio_t        o_p0_out,
  output mcu_pkg::gpio_t        o_p0_oe,
  output mcu_pkg::gpio_t        o_p1_out,
  output mcu_pkg::gpio_t        o_p1_oe
);

  logic            sys_reset_req;  // Combined reset request
  logic            hreset_n;       // System reset
  logic            sel_rom;
  logic            sel_sram;
  logic            sel_gpio0;
  logic            sel_gpio1;
  mcu_pkg::hdata_t rom_rdata;
  mcu_pkg::hdata_t sram_rdata;
  mcu_pkg::hdata_t gpio0_rdata;
  mcu_pkg::hdata_t gpio1_rdata;

  // ------------------------------
  // Reset
  // ------------------------------
  // Software request, or lockup when enabled
  assign sys_reset_req = i_sysresetreq | (i_lockup & i_lockupreset);

  mcu_clkctrl #(.RST_HOLD(RST_HOLD)) u_clkctrl (
    .i_hclk          (i_hclk),
    .i_rst_n         (i_rst_n),
    .i_sys_reset_req (sys_reset_req),
    .o_poreset_n     (),  // No debug domain left on it
    .o_hreset_n      (hreset_n)
  );

  assign o_sysrst_n = hreset_n;

  // ------------------------------
  // Bus fabric and slaves
  // ------------------------------
  mcu_ahb_decoder u_decoder (
    .i_hclk (i_hclk), .i_hreset_n (hreset_n),
    .i_haddr (i_haddr), .i_htrans (i_htrans),
    .i_rom_rdata (rom_rdata), .i_sram_rdata (sram_rdata),
    .i_gpio0_rdata (gpio0_rdata), .i_gpio1_rdata (gpio1_rdata),
    .o_sel_rom (sel_rom), .o_sel_sram (sel_sram),
    .o_sel_gpio0 (sel_gpio0), .o_sel_gpio1 (sel_gpio1),
    .o_hrdata (o_hrdata), .o_hready (o_hready), .o_hresp (o_hresp)
  );

  mcu_ahb_rom #(.ROM_AW(ROM_AW)) u_rom (
    .i_hclk (i_hclk), .i_sel (sel_rom), .i_haddr (i_haddr), .o_hrdata (rom_rdata)
  );

  mcu_ahb_sram #(.SRAM_AW(SRAM_AW)) u_sram (
    .i_hclk (i_hclk), .i_sel (sel_sram), .i_hwrite (i_hwrite), .i_haddr (i_haddr),
    .i_hsize (i_hsize), .i_hwdata (i_hwdata), .o_hrdata (sram_rdata)
  );

  mcu_ahb_gpio u_gpio0 (                          // Port 0
    .i_hclk (i_hclk), .i_hreset_n (hreset_n), .i_sel (sel_gpio0), .i_hwrite (i_hwrite),
    .i_haddr (i_haddr), .i_hsize (i_hsize), .i_hwdata (i_hwdata), .i_pin (i_p0_in),
    .o_hrdata (gpio0_rdata), .o_pin_out (o_p0_out), .o_pin_oe (o_p0_oe)
  );

  mcu_ahb_gpio u_gpio1 (                          // Port 1
    .i_hclk (i_hclk), .i_hreset_n (hreset_n), .i_sel (sel_gpio1), .i_hwrite (i_hwrite),
    .i_haddr (i_haddr), .i_hsize (i_hsize), .i_hwdata (i_hwdata), .i_pin (i_p1_in),
    .o_hrdata (gpio1_rdata), .o_pin_out (o_p1_out), .o_pin_oe (o_p1_oe)
  );

endmodule

`default_nettype wire

//--- tb_mcu.sv
`default_nettype none

module tb_mcu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_HOLD = 4;   // Same as the DUT default
  localparam int WAIT_MAX = 30;  // Cycle limit of every wait

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_PINS, OP_RSTREQ} op_t;

  // Addr holds the port for OP_PINS and the reset source for OP_RSTREQ
  typedef struct packed {
    op_t             op;
    mcu_pkg::haddr_t addr;
    mcu_pkg::hsize_t size;
    mcu_pkg::hdata_t wdata;
    mcu_pkg::hdata_t exp_rdata;
    logic            exp_err;   // ERROR response or reset drop for OP_RSTREQ
    logic [63:0]     exp_pins;  // {p1_oe, p1_out, p0_oe, p0_out} after the row
  } step_t;

  logic             hclk;
  logic             rst_n;
  logic             sysresetreq;
  logic             lockup;
  logic             lockupreset;
  mcu_pkg::haddr_t  haddr;
  mcu_pkg::htrans_t htrans;
  mcu_pkg::hsize_t  hsize;
  logic             hwrite;
  mcu_pkg::hdata_t  hwdata;
  mcu_pkg::gpio_t   p0_in;
  mcu_pkg::gpio_t   p1_in;
  mcu_pkg::hdata_t  hrdata;
  logic             hready;
  logic             hresp;
  logic             sysrst_n;
  mcu_pkg::gpio_t   p0_out;
  mcu_pkg::gpio_t   p0_oe;
  mcu_pkg::gpio_t   p1_out;
  mcu_pkg::gpio_t   p1_oe;

  mcu_pkg::hdata_t  rom_img  [16];   // Image from rom.hex
  mcu_pkg::hdata_t  sram_ref [256];  // 1 KiB of words
  mcu_pkg::gpio_t   dout_ref [2];
  mcu_pkg::gpio_t   oen_ref  [2];
  mcu_pkg::gpio_t   pins_ref [2];    // Pad levels last applied
  step_t            steps [$];
  int               mismatch_cnt;
  int               timeout_cnt;

  mcu_top #(.RST_HOLD(RST_HOLD)) UUT (
    .i_hclk (hclk), .i_rst_n (rst_n), .i_sysresetreq (sysresetreq),
    .i_lockup (lockup), .i_lockupreset (lockupreset),
    .i_haddr (haddr), .i_htrans (htrans), .i_hsize (hsize), .i_hwrite (hwrite),
    .i_hwdata (hwdata), .i_p0_in (p0_in), .i_p1_in (p1_in),
    .o_hrdata (hrdata), .o_hready (hready), .o_hresp (hresp), .o_sysrst_n (sysrst_n),
    .o_p0_out (p0_out), .o_p0_oe (p0_oe), .o_p1_out (p1_out), .o_p1_oe (p1_oe)
  );

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;  // 100 MHz
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0d ns: %s", $time, msg);
    mismatch_cnt++;
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int region_of(input mcu_pkg::haddr_t addr);
    mcu_pkg::haddr_t base;
    base = addr & mcu_pkg::REGION_MASK;
    if (base == mcu_pkg::BASE_ROM) return 0;
    if (base == mcu_pkg::BASE_SRAM) return 1;
    if (base == mcu_pkg::BASE_GPIO0) return 2;
    if (base == mcu_pkg::BASE_GPIO1) return 3;
    return -1;  // Default slave
  endfunction

  function automatic mcu_pkg::haddr_t gpio_addr(input int port, input mcu_pkg::rofs_t ofs);
    return (port == 0 ? mcu_pkg::BASE_GPIO0 : mcu_pkg::BASE_GPIO1) | 32'(ofs);
  endfunction

  function automatic mcu_pkg::hdata_t expect_read(input mcu_pkg::haddr_t addr);
    int port;
    port = region_of(addr) - 2;
    if (region_of(addr) == 0) return rom_img[addr[5:2]];   // Wraps every 16 words
    if (region_of(addr) == 1) return sram_ref[addr[9:2]];  // Wraps every 1 KiB
    if (port >= 0) begin
      if (addr[11:0] == mcu_pkg::GPIO_DATA_OFS) return {16'h0000, pins_ref[port]};
      if (addr[11:0] == mcu_pkg::GPIO_DOUT_OFS) return {16'h0000, dout_ref[port]};
      if (addr[11:0] == mcu_pkg::GPIO_OEN_OFS) return {16'h0000, oen_ref[port]};
    end
    return '0;  // Unused offset or unmapped
  endfunction

  task automatic add_step(input op_t op, input mcu_pkg::haddr_t addr,
                          input mcu_pkg::hsize_t size, input mcu_pkg::hdata_t wdata,
                          input mcu_pkg::hdata_t exp_rdata, input logic exp_err);
    step_t st;
    st.op        = op;
    st.addr      = addr;
    st.size      = size;
    st.wdata     = wdata;
    st.exp_rdata = exp_rdata;
    st.exp_err   = exp_err;
    st.exp_pins  = {oen_ref[1], dout_ref[1], oen_ref[0], dout_ref[0]};
    steps.push_back(st);
  endtask

  task automatic read_step(input mcu_pkg::haddr_t addr);
    add_step(OP_READ, addr, mcu_pkg::HSIZE_WORD, '0, expect_read(addr), region_of(addr) < 0);
  endtask

  task automatic write_step(input mcu_pkg::haddr_t addr, input mcu_pkg::hsize_t size,
                            input mcu_pkg::hdata_t data);
    int nbytes;
    int first;
    int port;
    nbytes = 1 << size;
    first  = (int'(addr[1:0]) / nbytes) * nbytes;  // Aligned start lane
    port   = region_of(addr) - 2;
    if (region_of(addr) == 1) begin
      for (int b = first; b < first + nbytes; b++) begin
        sram_ref[addr[9:2]][8*b +: 8] = data[8*b +: 8];  // Lane b from the same lane
      end
    end else if (port >= 0 && size == mcu_pkg::HSIZE_WORD) begin
      if (addr[11:0] == mcu_pkg::GPIO_DOUT_OFS) dout_ref[port] = data[15:0];
      if (addr[11:0] == mcu_pkg::GPIO_OEN_OFS) oen_ref[port] = data[15:0];
    end
    add_step(OP_WRITE, addr, size, data, '0, region_of(addr) < 0);
  endtask

  task automatic pins_step(input int port, input mcu_pkg::gpio_t val);
    pins_ref[port] = val;
    add_step(OP_PINS, port, mcu_pkg::HSIZE_WORD, {16'h0000, val}, '0, 1'b0);
  endtask

  // Source 0 is the request pin; 1 and 2 are lockup with and without enable
  task automatic reset_step(input int src);
    if (src != 2) begin
      dout_ref = '{default: '0};
      oen_ref  = '{default: '0};
    end
    add_step(OP_RSTREQ, src, mcu_pkg::HSIZE_WORD, '0, '0, src != 2);
  endtask

  task automatic build_steps();
    mcu_pkg::hdata_t rnd;
    for (int p = 0; p < 2; p++) begin
      read_step(gpio_addr(p, mcu_pkg::GPIO_DOUT_OFS));
      read_step(gpio_addr(p, mcu_pkg::GPIO_OEN_OFS));
    end
    for (int i = 0; i < 16; i++) read_step(mcu_pkg::BASE_ROM + 4 * i);
    write_step(mcu_pkg::BASE_ROM + 8, mcu_pkg::HSIZE_WORD, $urandom());  // No effect
    read_step(mcu_pkg::BASE_ROM + 8);
    read_step(mcu_pkg::BASE_ROM + 32'h48);  // Wraps onto word 2
    for (int i = 0; i < 8; i++) write_step(mcu_pkg::BASE_SRAM + 4 * i, mcu_pkg::HSIZE_WORD,
                                           $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h3FC, mcu_pkg::HSIZE_WORD, $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h006, mcu_pkg::HSIZE_HALF, $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h008, mcu_pkg::HSIZE_HALF, $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h00D, mcu_pkg::HSIZE_BYTE, $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h013, mcu_pkg::HSIZE_BYTE, $urandom());
    write_step(mcu_pkg::BASE_SRAM + 32'h416, mcu_pkg::HSIZE_BYTE, $urandom());  // Word 5
    write_step(mcu_pkg::BASE_SRAM + 32'h418, mcu_pkg::HSIZE_WORD, $urandom());  // Word 6
    write_step(mcu_pkg::BASE_SRAM + 32'h7FE, mcu_pkg::HSIZE_HALF, $urandom());  // Last word
    for (int i = 0; i < 8; i++) read_step(mcu_pkg::BASE_SRAM + 4 * i);
    read_step(mcu_pkg::BASE_SRAM + 32'h3FC);
    read_step(mcu_pkg::BASE_SRAM + 32'hC04);  // Wrapped read of word 1
    for (int p = 0; p < 2; p++) begin
      write_step(gpio_addr(p, mcu_pkg::GPIO_DOUT_OFS), mcu_pkg::HSIZE_WORD, $urandom());
      write_step(gpio_addr(p, mcu_pkg::GPIO_OEN_OFS), mcu_pkg::HSIZE_WORD, $urandom());
      read_step(gpio_addr(p, mcu_pkg::GPIO_DOUT_OFS));
      read_step(gpio_addr(p, mcu_pkg::GPIO_OEN_OFS));
      write_step(gpio_addr(p, mcu_pkg::GPIO_DOUT_OFS), mcu_pkg::HSIZE_BYTE, $urandom());
      read_step(gpio_addr(p, mcu_pkg::GPIO_DOUT_OFS));  // Byte write ignored
      rnd = $urandom();
      pins_step(p, rnd[15:0]);
      read_step(gpio_addr(p, mcu_pkg::GPIO_DATA_OFS));
      read_step(gpio_addr(p, 12'h00C));  // Unused offset
    end
    read_step(32'h3000_0000);
    read_step(mcu_pkg::BASE_ROM + 4);
    write_step(32'h4001_2000, mcu_pkg::HSIZE_WORD, $urandom());
    read_step(gpio_addr(0, mcu_pkg::GPIO_DOUT_OFS));
    read_step(32'h0000_1000);  // Just past the ROM region
    read_step(mcu_pkg::BASE_SRAM + 4);
    reset_step(0);
    read_step(gpio_addr(0, mcu_pkg::GPIO_DOUT_OFS));
    read_step(gpio_addr(1, mcu_pkg::GPIO_OEN_OFS));
    for (int i = 0; i < 4; i++) read_step(mcu_pkg::BASE_SRAM + 4 * i);  // Contents kept
    write_step(gpio_addr(1, mcu_pkg::GPIO_DOUT_OFS), mcu_pkg::HSIZE_WORD, $urandom());
    write_step(gpio_addr(1, mcu_pkg::GPIO_OEN_OFS), mcu_pkg::HSIZE_WORD, $urandom());
    reset_step(2);
    read_step(gpio_addr(1, mcu_pkg::GPIO_DOUT_OFS));
    reset_step(1);
    read_step(gpio_addr(1, mcu_pkg::GPIO_DOUT_OFS));
    read_step(gpio_addr(1, mcu_pkg::GPIO_OEN_OFS));
    read_step(mcu_pkg::BASE_SRAM + 32'h3FC);
  endtask

  // ------------------------------
  // Bus and pin drivers
  // ------------------------------
  task automatic run_transfer(input step_t st, output mcu_pkg::hdata_t rdata,
                              output logic err, output int stall_n);
    @(posedge hclk);
    haddr  <= st.addr;  // Address phase
    htrans <= mcu_pkg::HTRANS_NONSEQ;
    hsize  <= st.size;
    hwrite <= (st.op == OP_WRITE);
    @(posedge hclk);
    htrans <= mcu_pkg::HTRANS_IDLE;  // Idle through any stall
    hwdata <= st.wdata;
    stall_n = 0;
    @(negedge hclk);
    while (!hready && stall_n < WAIT_MAX) begin
      if (!hresp) report_mismatch("stall cycle without ERROR response");
      stall_n++;
      @(negedge hclk);
    end
    if (!hready) begin
      $display("Timeout at %0d ns: bus never became ready for address %h", $time, st.addr);
      timeout_cnt++;
    end
    rdata = hrdata;
    err   = hresp;
  endtask

  task automatic apply_pins(input step_t st);
    @(posedge hclk);
    if (st.addr[0]) p1_in <= st.wdata[15:0];
    else p0_in <= st.wdata[15:0];
    repeat (3) @(posedge hclk);  // Synchronizer settles
  endtask

  task automatic wait_release(output int low_n);
    low_n = 0;
    @(negedge hclk);
    while (sysrst_n !== 1'b1 && low_n < WAIT_MAX) begin
      low_n++;
      @(negedge hclk);
    end
    if (sysrst_n !== 1'b1) begin
      $display("Timeout at %0d ns: system reset was never released", $time);
      timeout_cnt++;
    end
  endtask

  task automatic request_reset(input step_t st);
    int   wait_n;
    int   low_n;
    logic dropped;
    @(posedge hclk);
    sysresetreq <= (st.addr == 0);
    lockup      <= (st.addr != 0);
    lockupreset <= (st.addr == 1);
    dropped = 1'b0;
    wait_n  = 0;
    while (!dropped && wait_n < WAIT_MAX) begin  // Full window when no drop is due
      @(negedge hclk);
      dropped = !sysrst_n;
      wait_n++;
    end
    @(posedge hclk);
    sysresetreq <= 1'b0;  // Request falls here
    lockup      <= 1'b0;
    lockupreset <= 1'b0;
    if (st.exp_err && !dropped) begin
      $display("Timeout at %0d ns: reset source %0d never dropped the reset", $time, st.addr);
      timeout_cnt++;
    end else if (!st.exp_err && dropped) begin
      report_mismatch("lockup without reset enable dropped the system reset");
    end
    wait_release(low_n);
    if (st.exp_err && dropped && low_n != RST_HOLD) begin
      report_mismatch($sformatf("reset held %0d cycles after request, expected %0d",
                                low_n, RST_HOLD));
    end
  endtask

  task automatic check_pins(input step_t st, input int idx);
    if ({p1_oe, p1_out, p0_oe, p0_out} !== st.exp_pins) begin
      report_mismatch($sformatf("row %0d pins %h, expected %h", idx,
                                {p1_oe, p1_out, p0_oe, p0_out}, st.exp_pins));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    step_t           st;
    mcu_pkg::hdata_t rdata;
    logic            err;
    int              stall_n;
    int              low_n;
    void'($urandom(32'h78b4));  // Single seed for the run
    rst_n        = 1'b0;
    sysresetreq  = 1'b0;
    lockup       = 1'b0;
    lockupreset  = 1'b0;
    haddr        = '0;
    htrans       = mcu_pkg::HTRANS_IDLE;
    hsize        = mcu_pkg::HSIZE_WORD;
    hwrite       = 1'b0;
    hwdata       = '0;
    p0_in        = '0;
    p1_in        = '0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    pins_ref     = '{default: '0};
    dout_ref     = '{default: '0};
    oen_ref      = '{default: '0};
    $readmemh("rom.hex", rom_img);
    build_steps();
    repeat (8) @(posedge hclk);  // Power-on reset held
    if (hready !== 1'b1 || hresp !== 1'b0) report_mismatch("bus response wrong in reset");
    if ({p1_oe, p1_out, p0_oe, p0_out} !== '0) report_mismatch("pins driven in reset");
    rst_n <= 1'b1;
    wait_release(low_n);
    for (int i = 0; i < steps.size() && timeout_cnt == 0; i++) begin
      st = steps[i];
      case (st.op)
        OP_READ, OP_WRITE: begin
          run_transfer(st, rdata, err, stall_n);
          if (err !== st.exp_err) begin
            report_mismatch($sformatf("row %0d address %h response %b, expected %b",
                                      i, st.addr, err, st.exp_err));
          end
          if (stall_n != (st.exp_err ? 1 : 0)) begin
            report_mismatch($sformatf("row %0d address %h stalled %0d cycles",
                                      i, st.addr, stall_n));
          end
          if ((st.op == OP_READ || st.exp_err) && rdata !== st.exp_rdata) begin
            report_mismatch($sformatf("row %0d address %h read %h, expected %h",
                                      i, st.addr, rdata, st.exp_rdata));
          end
        end
        OP_PINS: apply_pins(st);
        default: request_reset(st);
      endcase
      @(negedge hclk);
      check_pins(st, i);  // Registers land one edge after the data phase
    end
    $display("Error count: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rom.hex
// One 32-bit program word per line, for word addresses 0 to 15
20000400
000000c1
000000d3
000000d5
4a0c2100
60114a0b
2201490b
600a4b0a
3b01e7fe
d1fd2b00
e7f9bf00
40010004
40010008
0000ffff
a5c3e781
12345678

//--- project.f
mcu_pkg.sv
mcu_clkctrl.sv
mcu_ahb_decoder.sv
mcu_ahb_rom.sv
mcu_ahb_sram.sv
mcu_ahb_gpio.sv
mcu_top.sv
tb_mcu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches its output for the passing line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module tb_mcu \
  -f project.f -o sim_mcu &&
./obj_dir/sim_mcu | tee /dev/stderr | grep -qx "Done: no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
